//--- rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first aligned fetch address out of reset
`define FETCH_RESET_PC 32'h1c000000

// fetch groups held between the bus and the backend
`define FETCH_QUEUE_DEPTH 4

`endif

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // one aligned instruction pair, pc bit 2 set means slot 0 is skipped
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
    } fetch_group_t;

    typedef enum logic [1:0] {
        BT_NONE     = 2'd0,
        BT_DIRECT   = 2'd1,
        BT_COND     = 2'd2,
        BT_INDIRECT = 2'd3
    } btype_e;

    // per-slot masks, bit 0 is slot 0
    typedef struct packed {
        logic [1:0] ibar_flag;
        logic [1:0] csr_flag;
        logic [1:0] tlb_flag;
        logic [1:0] priv_flag;
        btype_e     btype;
    } predecode_t;

    // wishbone classic read request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_BUS,
        FS_HALT
    } fetch_state_e;

endpackage

`default_nettype wire

//--- rtl/pre_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pre_decoder import fetch_pkg::*; (
    input  fetch_group_t group,
    output predecode_t   predecode
);

    logic [1:0] slot_valid;
    logic [1:0] ibar_raw;
    logic [1:0] csr_raw;
    logic [1:0] tlb_raw;
    btype_e     type0;
    btype_e     type1;

    // ibar: 00111 opcode group with bit 15 set
    function automatic logic is_ibar(input logic [31:0] w);
        return (w[31:27] == 5'b00111) && w[15];
    endfunction

    // csrwr / csrxchg only, csrrd has rj == 0
    function automatic logic is_csr_write(input logic [31:0] w);
        return (w[31:24] == 8'b00000100) && (w[9:5] != 5'd0);
    endfunction

    function automatic logic is_tlb(input logic [31:0] w);
        logic srch;
        logic rd;
        logic inv;
        srch = (w == 32'h06482800);
        rd   = (w == 32'h06482c00);
        // invtlb carries op and register fields below bit 15
        inv  = (w[31:15] == 17'b00000110010010011);
        return srch || rd || inv;
    endfunction

    function automatic btype_e branch_type(input logic [31:0] w);
        btype_e t;
        if (w[31:27] == 5'b01010) begin
            // b, bl
            t = BT_DIRECT;
        end else if (w[31:26] == 6'b010011) begin
            // jirl
            t = BT_INDIRECT;
        end else if ((w[31:27] == 5'b01011) || (w[31:28] == 4'b0110)) begin
            t = BT_COND;
        end else begin
            t = BT_NONE;
        end
        return t;
    endfunction

    // slot 0 lies before the pc when bit 2 is set
    assign slot_valid = {1'b1, ~group.pc[2]};

    assign ibar_raw = {is_ibar(group.inst1), is_ibar(group.inst0)};
    assign csr_raw  = {is_csr_write(group.inst1), is_csr_write(group.inst0)};
    assign tlb_raw  = {is_tlb(group.inst1), is_tlb(group.inst0)};

    assign type0 = slot_valid[0] ? branch_type(group.inst0) : BT_NONE;
    assign type1 = branch_type(group.inst1);

    assign predecode.ibar_flag = ibar_raw & slot_valid;
    assign predecode.csr_flag  = csr_raw & slot_valid;
    assign predecode.tlb_flag  = tlb_raw & slot_valid;
    assign predecode.priv_flag = (ibar_raw | csr_raw | tlb_raw) & slot_valid;

    // earlier slot decides the group type
    always_comb begin
        if (type0 != BT_NONE) begin
            predecode.btype = type0;
        end else begin
            predecode.btype = type1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_queue import fetch_pkg::*; #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         push,
    input  fetch_group_t push_group,
    output logic         full,
    input  logic         pop,
    output logic         head_valid,
    output fetch_group_t head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_group_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign full       = (count == CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    // group storage
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_group;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count tracks occupancy with simultaneous push and pop
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // wishbone classic read master
    output wb_req_t      wb_req,
    input  logic [63:0]  wb_dat,
    input  logic         wb_ack,

    // queue status and backend handshake
    input  logic         queue_full,
    input  logic         head_valid,
    input  logic         issue_ready,
    input  predecode_t   head_predecode,

    input  logic         redirect_valid,
    input  logic [31:0]  redirect_pc,

    output logic         push,
    output fetch_group_t push_group,
    output logic         pop,
    output logic         flush
);

    fetch_state_e state;
    fetch_state_e state_nxt;

    logic [31:0] pc;
    logic [31:0] pc_aligned;
    logic        discard;
    logic        bus_done;
    logic        start_req;
    logic        halt_group;
    logic        halt_take;

    assign pc_aligned = {pc[31:3], 3'b000};
    assign bus_done   = wb_req.cyc && wb_ack;

    // privileged ops and unpredicted jumps stop fetch
    assign halt_group = (|head_predecode.priv_flag) ||
                        (head_predecode.btype == BT_DIRECT) ||
                        (head_predecode.btype == BT_INDIRECT);

    // redirect takes priority over an issue transfer
    assign pop       = head_valid && issue_ready && !redirect_valid;
    assign halt_take = pop && halt_group;
    assign flush     = redirect_valid || halt_take;

    assign push             = bus_done && !discard && !flush;
    assign push_group.pc    = pc;
    assign push_group.inst0 = wb_dat[31:0];
    assign push_group.inst1 = wb_dat[63:32];

    assign start_req = (state == FS_IDLE) && !queue_full && !flush;

    always_comb begin
        state_nxt = state;
        if (redirect_valid) begin
            // an unfinished bus cycle still has to see its ack
            state_nxt = (wb_req.cyc && !wb_ack) ? FS_BUS : FS_IDLE;
        end else if (halt_take) begin
            state_nxt = FS_HALT;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (start_req) begin
                        state_nxt = FS_BUS;
                    end
                end
                FS_BUS: begin
                    if (bus_done) begin
                        state_nxt = FS_IDLE;
                    end
                end
                default: begin
                    state_nxt = state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FS_IDLE;
            pc         <= `FETCH_RESET_PC;
            discard    <= 1'b0;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.adr <= '0;
        end else begin
            state <= state_nxt;

            // cyc and stb held until ack
            if (bus_done) begin
                wb_req.cyc <= 1'b0;
                wb_req.stb <= 1'b0;
            end else if (start_req) begin
                wb_req.cyc <= 1'b1;
                wb_req.stb <= 1'b1;
                wb_req.adr <= pc_aligned;
            end

            // data of a cancelled path is dropped at its ack
            if (bus_done) begin
                discard <= 1'b0;
            end else if (wb_req.cyc && flush) begin
                discard <= 1'b1;
            end

            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (push) begin
                pc <= pc_aligned + 32'd8;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_frontend import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // instruction memory
    output wb_req_t      wb_req,
    input  logic [63:0]  wb_dat,
    input  logic         wb_ack,

    // backend issue port
    output logic         issue_valid,
    input  logic         issue_ready,
    output fetch_group_t issue_group,
    output predecode_t   issue_predecode,

    input  logic         redirect_valid,
    input  logic [31:0]  redirect_pc
);

    logic         push;
    logic         pop;
    logic         flush;
    logic         queue_full;
    fetch_group_t push_group;

    fetch_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .wb_req         (wb_req),
        .wb_dat         (wb_dat),
        .wb_ack         (wb_ack),
        .queue_full     (queue_full),
        .head_valid     (issue_valid),
        .issue_ready    (issue_ready),
        .head_predecode (issue_predecode),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .push           (push),
        .push_group     (push_group),
        .pop            (pop),
        .flush          (flush)
    );

    // queue head is the issue group
    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) queue_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .push_group (push_group),
        .full       (queue_full),
        .pop        (pop),
        .head_valid (issue_valid),
        .head       (issue_group)
    );

    pre_decoder predec_i (
        .group     (issue_group),
        .predecode (issue_predecode)
    );

endmodule

`default_nettype wire

//--- tests/tb_imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem_model import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  wb_req_t     wb_req,
    output logic [63:0] wb_dat,
    output logic        wb_ack
);

    // words placed by the testbench, everything else is filler
    logic [31:0] words [logic [31:0]];
    logic        busy;
    logic [1:0]  wait_left;

    // andi into r0 with address bits mixed in, still a nop
    function automatic logic [31:0] filler_word(input logic [31:0] addr);
        logic [16:0] mix;
        mix = addr[16:0] ^ {2'b00, addr[31:17]};
        return 32'h03400000 | {10'b0, mix, 5'b0};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return filler_word(addr);
    endfunction

    task automatic set_word(input logic [31:0] addr, input logic [31:0] w);
        words[addr] = w;
    endtask

    // registered ack after 0 to 3 extra wait states
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            wait_left <= 2'd0;
            wb_ack    <= 1'b0;
            wb_dat    <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (busy) begin
                if (wait_left == 2'd0) begin
                    busy   <= 1'b0;
                    wb_ack <= 1'b1;
                    wb_dat <= {word_at(wb_req.adr + 32'd4), word_at(wb_req.adr)};
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end else if (wb_req.cyc && wb_req.stb && !wb_ack) begin
                busy      <= 1'b1;
                wait_left <= 2'($urandom % 4);
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch_frontend import fetch_pkg::*; ();

    localparam int WAIT_LIMIT  = 200;
    localparam int TAIL_GROUPS = 40;

    logic         clk;
    logic         rst;
    wb_req_t      wb_req;
    logic [63:0]  wb_dat;
    logic         wb_ack;
    logic         issue_valid;
    logic         issue_ready;
    fetch_group_t issue_group;
    predecode_t   issue_predecode;
    logic         redirect_valid;
    logic [31:0]  redirect_pc;
    logic         halted;

    fetch_frontend dut_i (
        .clk             (clk),
        .rst             (rst),
        .wb_req          (wb_req),
        .wb_dat          (wb_dat),
        .wb_ack          (wb_ack),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .issue_group     (issue_group),
        .issue_predecode (issue_predecode),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

    tb_imem_model imem_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [95:0] got,
                                   input logic [95:0] expected);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("test failed");
        $fatal(1);
    endtask

    // {ibar, csr write, tlb, btype}
    function automatic logic [4:0] word_class(input logic [31:0] w);
        logic [4:0] c;
        c = '0;
        c[4] = (w & 32'hf8008000) == 32'h38008000;
        c[3] = ((w & 32'hff000000) == 32'h04000000) && ((w & 32'h000003e0) != 0);
        c[2] = (w == 32'h06482800) || (w == 32'h06482c00) ||
               ((w & 32'hffff8000) == 32'h06498000);
        if ((w & 32'hf8000000) == 32'h50000000) begin
            c[1:0] = BT_DIRECT;
        end else if ((w & 32'hfc000000) == 32'h4c000000) begin
            c[1:0] = BT_INDIRECT;
        end else if (((w & 32'hf8000000) == 32'h58000000) ||
                     ((w & 32'hf0000000) == 32'h60000000)) begin
            c[1:0] = BT_COND;
        end
        return c;
    endfunction

    function automatic predecode_t expected_predecode(input logic [31:0] pc,
                                                      input logic [31:0] w0,
                                                      input logic [31:0] w1);
        logic [4:0] c0;
        logic [4:0] c1;
        predecode_t p;
        c0 = word_class(w0);
        c1 = word_class(w1);
        // slot 0 sits before the pc
        if (pc[2]) begin
            c0 = '0;
        end
        p.ibar_flag = {c1[4], c0[4]};
        p.csr_flag  = {c1[3], c0[3]};
        p.tlb_flag  = {c1[2], c0[2]};
        p.priv_flag = {|c1[4:2], |c0[4:2]};
        p.btype     = (c0[1:0] != 2'd0) ? btype_e'(c0[1:0]) : btype_e'(c1[1:0]);
        return p;
    endfunction

    function automatic logic causes_halt(input predecode_t p);
        return (p.priv_flag != 2'b00) || (p.btype == BT_DIRECT) ||
               (p.btype == BT_INDIRECT);
    endfunction

    task automatic load_program();
        imem_i.set_word(32'h1c000010, 32'h58000000);  // beq
        imem_i.set_word(32'h1c000014, 32'h04000004);  // csrrd
        imem_i.set_word(32'h1c000024, 32'h38728000);  // ibar
        imem_i.set_word(32'h1c000040, 32'h04000421);  // csrwr masked by pc bit 2
        imem_i.set_word(32'h1c00004c, 32'h68000000);  // bltu
        imem_i.set_word(32'h1c000050, 32'h50000000);  // b
        imem_i.set_word(32'h1c000084, 32'h06482800);  // tlbsrch
        imem_i.set_word(32'h1c0000a0, 32'h38728000);  // ibar masked by pc bit 2
        imem_i.set_word(32'h1c0000a8, 32'h4c000020);  // jirl
        imem_i.set_word(32'h1c0000c8, 32'h06498005);  // invtlb
        imem_i.set_word(32'h1c0000cc, 32'h04000421);  // csrwr
        imem_i.set_word(32'h1c000114, 32'h54000000);  // bl in slot 1
    endtask

    // random backend stall while the held group stays put
    task automatic wait_transfer(output fetch_group_t g, output predecode_t p);
        int           cycles;
        logic         got;
        logic         holding;
        fetch_group_t held_g;
        predecode_t   held_p;
        cycles  = 0;
        got     = 1'b0;
        holding = 1'b0;
        while (!got) begin
            @(negedge clk);
            redirect_valid = 1'b0;
            if (holding) begin
                assert (issue_valid) else report_error("issue_valid dropped during a stall");
                assert (issue_group == held_g)
                    else report_mismatch("issue_group", issue_group, held_g);
                assert (issue_predecode == held_p)
                    else report_mismatch("issue_predecode", 96'(issue_predecode), 96'(held_p));
            end
            issue_ready = ($urandom % 4) != 0;
            holding = issue_valid && !issue_ready;
            held_g  = issue_group;
            held_p  = issue_predecode;
            if (issue_valid && issue_ready) begin
                g   = issue_group;
                p   = issue_predecode;
                got = 1'b1;
            end
            @(posedge clk);
            cycles++;
            assert (cycles < WAIT_LIMIT) else report_error("timed out waiting for a group");
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            issue_ready = ($urandom % 4) != 0;
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(negedge clk);
        issue_ready    = ($urandom % 4) != 0;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(posedge clk);
        halted = 1'b0;
    endtask

    halt_keeps_valid_low: assert property (@(posedge clk) disable iff (rst)
        halted |-> !issue_valid)
        else report_error("issue_valid high while fetch is halted");

    initial begin
        logic [31:0]  targets [$];
        fetch_group_t g;
        predecode_t   p;
        predecode_t   exp_p;
        logic [31:0]  exp_pc;
        logic [31:0]  base;
        logic [31:0]  w0;
        logic [31:0]  w1;
        int           tail;

        void'($urandom(32'h9a28));
        rst            = 1'b1;
        issue_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        halted         = 1'b0;
        load_program();
        targets = '{32'h1c000044, 32'h1c000080, 32'h1c0000a4,
                    32'h1c0000c0, 32'h1c000110, 32'h1c000200};

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (!wb_req.cyc && !wb_req.stb) else report_error("bus active in reset");
            assert (!issue_valid) else report_error("issue_valid high in reset");
        end
        rst = 1'b0;

        exp_pc = `FETCH_RESET_PC;
        tail   = 0;
        while (tail < TAIL_GROUPS) begin
            wait_transfer(g, p);
            base  = {exp_pc[31:3], 3'b000};
            w0    = imem_i.word_at(base);
            w1    = imem_i.word_at(base + 32'd4);
            exp_p = expected_predecode(exp_pc, w0, w1);
            assert (g.pc == exp_pc)
                else report_mismatch("issue_group.pc", 96'(g.pc), 96'(exp_pc));
            assert (g.inst0 == w0)
                else report_mismatch("issue_group.inst0", 96'(g.inst0), 96'(w0));
            assert (g.inst1 == w1)
                else report_mismatch("issue_group.inst1", 96'(g.inst1), 96'(w1));
            assert (p == exp_p)
                else report_mismatch("issue_predecode", 96'(p), 96'(exp_p));
            if (causes_halt(exp_p)) begin
                halted = 1'b1;
                idle_cycles(1 + $urandom % 5);
                exp_pc = targets.pop_front();
                send_redirect(exp_pc);
            end else begin
                exp_pc = base + 32'd8;
                if (targets.size() == 0) begin
                    tail++;
                end
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_frontend.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pre_decoder.sv
rtl/fetch_queue.sv
rtl/fetch_ctrl.sv
rtl/fetch_frontend.sv
tests/tb_imem_model.sv
tests/tb_fetch_frontend.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f fetch_frontend.f --top-module tb_fetch_frontend -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_fetch_frontend)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
